/* bench/rapid_recovery_props.sv */
`timescale 1ns/1ps

module recovery_ctrl_props (
  input logic clk_i,
  input logic rst_ni,
  input recovery_pkg::recovery_mode_e mode_i,
  input logic debug_halt_i,
  input logic setback_i,
  input logic debug_req_i,
  input logic debug_resume_i,
  input logic recovery_finished_i,
  input logic restore_enable_i
);

  import recovery_pkg::*;

  // Number of assertion failures so far
  int unsigned fail_count = 0;

  // Setback is a one cycle pulse
  setback_single_cycle: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    setback_i |=> !setback_i
  ) else begin
    fail_count++;
    $error("setback_o held high for more than one cycle");
  end

  // Pulse lines up with the first HALT cycle
  setback_in_halt: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(setback_i) |-> (mode_i == HALT)
  ) else begin
    fail_count++;
    $error("setback_o rose outside the first HALT cycle");
  end

  // Halt request opens together with the setback pulse
  debug_req_starts_with_setback: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(debug_req_i) |-> setback_i
  ) else begin
    fail_count++;
    $error("debug_req_o rose outside the first HALT cycle");
  end

  // Request held until the core acknowledges
  debug_req_held: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    debug_req_i && !debug_halt_i |=> debug_req_i
  ) else begin
    fail_count++;
    $error("debug_req_o dropped before debug_halt_i was seen");
  end

  // Acknowledge ends the request and starts the replay
  debug_req_released: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    debug_req_i && debug_halt_i |=> !debug_req_i && restore_enable_i
  ) else begin
    fail_count++;
    $error("debug_req_o not released into RESTORE after debug_halt_i");
  end

  // One full pass over half the register file
  restore_sixteen_cycles: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(restore_enable_i) |-> restore_enable_i [*16] ##1 !restore_enable_i
  ) else begin
    fail_count++;
    $error("RESTORE did not last exactly 16 cycles");
  end

  // Finish and resume go out together on the sixteenth restore cycle
  finished_implies_resume: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    recovery_finished_i |-> debug_resume_i && $past(restore_enable_i, 15) &&
                            !$past(restore_enable_i, 16)
  ) else begin
    fail_count++;
    $error("recovery_finished_o without debug_resume_o on the last restore step");
  end

endmodule

// Attach to every controller instance
bind recovery_ctrl recovery_ctrl_props recovery_ctrl_props_inst (
  .clk_i               (clk_i),
  .rst_ni              (rst_ni),
  .mode_i              (mode_q),
  .debug_halt_i        (debug_halt_i),
  .setback_i           (setback_o),
  .debug_req_i         (debug_req_o),
  .debug_resume_i      (debug_resume_o),
  .recovery_finished_i (recovery_finished_o),
  .restore_enable_i    (restore_enable_o)
);

/* bench/rapid_recovery_tb.sv */
`timescale 1ns/1ps

`include "recovery_defs.svh"

module rapid_recovery_tb;

  import recovery_pkg::*;

  localparam int unsigned half_regs = `RR_NUM_REGS / 2;
  localparam int unsigned num_recoveries = 3;
  localparam int unsigned traffic_cycles = 200;
  localparam int unsigned idle_timeout = 2000;
  localparam int unsigned halt_timeout = 20;
  localparam int unsigned busy_timeout = 64;

  logic           clk_i;
  logic           rst_ni;
  logic           start_recovery_i;
  regfile_write_t core_rf_write_i;
  pc_t            core_pc_i;
  logic           core_pc_valid_i;
  logic           debug_halt_i;
  regfile_write_t recovery_rf_write_o;
  pc_t            recovery_pc_o;
  logic           recovery_pc_valid_o;
  logic           setback_o;
  logic           instr_lock_o;
  logic           debug_req_o;
  logic           debug_resume_o;
  logic           recovery_finished_o;

  // Reference shadow state
  rf_data_t    ref_mem [`RR_NUM_REGS];
  pc_t         ref_pc;
  logic [31:0] rng_state;
  int unsigned starts_sent;
  int unsigned recoveries_checked;
  int unsigned error_count;
  logic        compare_finished;

  // Failures seen by the bound controller assertions
  int unsigned assert_failures;

  rapid_recovery rapid_recovery_inst (.*);

  assign assert_failures =
    rapid_recovery_inst.recovery_ctrl_inst.recovery_ctrl_props_inst.fail_count;

  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Paired write expected for restore step k
  function automatic regfile_write_t expected_restore(input int unsigned k);
    regfile_write_t exp;
    exp.we_a    = 1'b1;
    exp.waddr_a = rf_addr_t'(k);
    exp.wdata_a = ref_mem[k];
    exp.we_b    = 1'b1;
    exp.waddr_b = rf_addr_t'(k + half_regs);
    exp.wdata_b = ref_mem[k + half_regs];
    return exp;
  endfunction

  task automatic report_failure(input string what);
    error_count++;
    $display("%s", what);
    $display("Simulation FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("error at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_pc(input string name, input pc_t got, input pc_t exp);
    if (got !== exp) begin
      report_failure($sformatf("error at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_rf_write(input string name, input regfile_write_t got,
                                input regfile_write_t exp);
    if (got !== exp) begin
      report_failure($sformatf("error at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic drive_quiet();
    start_recovery_i = 1'b0;
    core_rf_write_i  = '0;
    core_pc_i        = '0;
    core_pc_valid_i  = 1'b0;
  endtask

  // Random core traffic, stored in the model only when backup is running
  task automatic drive_random(input logic store, input logic allow_start);
    regfile_write_t wr;
    pc_t            pc;
    logic [31:0]    r;
    r          = next_random();
    wr.we_a    = r[0];
    wr.we_b    = r[1];
    wr.waddr_a = r[8:4];
    // Same address now and then, so port b priority gets exercised
    wr.waddr_b = (r[15:12] == 4'h0) ? r[8:4] : r[20:16];
    wr.wdata_a = next_random();
    wr.wdata_b = next_random();
    pc         = next_random();
    pc[1:0]    = 2'b00;
    core_rf_write_i  = wr;
    core_pc_i        = pc;
    core_pc_valid_i  = r[2];
    // Busy starts must be ignored
    start_recovery_i = allow_start && (r[27:25] == 3'b000);
    if (store) begin
      if (wr.we_a) begin
        ref_mem[wr.waddr_a] = wr.wdata_a;
      end
      if (wr.we_b) begin
        ref_mem[wr.waddr_b] = wr.wdata_b;
      end
      if (r[2]) begin
        ref_pc = pc;
      end
    end
  endtask

  // Noise while locked, until the compare process saw the finish
  task automatic drive_during_recovery(input int unsigned target);
    int unsigned cycles;
    cycles = 0;
    @(posedge clk_i);
    #2;
    while (recoveries_checked < target) begin
      drive_random(1'b0, 1'b1);
      @(posedge clk_i);
      #2;
      cycles++;
      if (cycles > busy_timeout) begin
        report_failure("timeout: recovery never reported finished");
      end
    end
    drive_quiet();
  endtask

  task automatic check_idle_outputs();
    check_bit("setback_o", setback_o, 1'b0);
    check_bit("instr_lock_o", instr_lock_o, 1'b0);
    check_bit("debug_req_o", debug_req_o, 1'b0);
    check_bit("debug_resume_o", debug_resume_o, 1'b0);
    check_bit("recovery_finished_o", recovery_finished_o, 1'b0);
    check_bit("recovery_pc_valid_o", recovery_pc_valid_o, 1'b0);
    check_bit("recovery_rf_write_o.we_a", recovery_rf_write_o.we_a, 1'b0);
    check_bit("recovery_rf_write_o.we_b", recovery_rf_write_o.we_b, 1'b0);
  endtask

  // Walks one recovery from the RESET cycle to the cycle after finish
  task automatic check_recovery(input int unsigned target);
    int unsigned halt_cycles;
    logic        halted;
    // RESET cycle, registered outputs not yet up
    @(negedge clk_i);
    check_bit("setback_o", setback_o, 1'b0);
    check_bit("instr_lock_o", instr_lock_o, 1'b0);
    check_bit("debug_req_o", debug_req_o, 1'b0);
    // First HALT cycle carries the setback pulse
    @(negedge clk_i);
    check_bit("setback_o", setback_o, 1'b1);
    halt_cycles = 0;
    halted = 1'b0;
    while (!halted) begin
      if (halt_cycles > 0) begin
        @(negedge clk_i);
        check_bit("setback_o", setback_o, 1'b0);
      end
      check_bit("debug_req_o", debug_req_o, 1'b1);
      check_bit("instr_lock_o", instr_lock_o, 1'b1);
      check_bit("recovery_pc_valid_o", recovery_pc_valid_o, 1'b0);
      halted = debug_halt_i;
      halt_cycles++;
      if (halt_cycles > halt_timeout) begin
        report_failure("timeout: core never acknowledged the halt request");
      end
    end
    // Restore pass, one register pair per cycle
    for (int k = 0; k < half_regs; k++) begin
      @(negedge clk_i);
      check_rf_write("recovery_rf_write_o", recovery_rf_write_o, expected_restore(k));
      check_pc("recovery_pc_o", recovery_pc_o, ref_pc);
      check_bit("recovery_pc_valid_o", recovery_pc_valid_o, 1'b1);
      check_bit("debug_req_o", debug_req_o, 1'b0);
      check_bit("setback_o", setback_o, 1'b0);
      check_bit("instr_lock_o", instr_lock_o, 1'b1);
      check_bit("debug_resume_o", debug_resume_o, k == half_regs - 1);
      check_bit("recovery_finished_o", recovery_finished_o, k == half_regs - 1);
    end
    recoveries_checked = target;
    // Lock released, back in IDLE
    @(negedge clk_i);
    check_idle_outputs();
  endtask

  // Stimulus
  initial begin
    clk_i              = 1'b0;
    rst_ni             = 1'b0;
    debug_halt_i       = 1'b0;
    drive_quiet();
    rng_state          = 32'h1f17ad12;
    ref_pc             = '0;
    starts_sent        = 0;
    recoveries_checked = 0;
    error_count        = 0;
    compare_finished   = 1'b0;
    for (int i = 0; i < `RR_NUM_REGS; i++) begin
      ref_mem[i] = '0;
    end
    repeat (16) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    for (int n = 1; n <= num_recoveries; n++) begin
      repeat (traffic_cycles) begin
        @(posedge clk_i);
        #2;
        drive_random(1'b1, 1'b0);
      end
      // Quiet bus around the pulse keeps the snapshot settled
      @(posedge clk_i);
      #2;
      drive_quiet();
      start_recovery_i = 1'b1;
      starts_sent++;
      @(posedge clk_i);
      #2;
      drive_quiet();
      drive_during_recovery(n);
    end
    for (int t = 0; !compare_finished; t++) begin
      if (t > busy_timeout) begin
        report_failure("timeout: compare process did not complete");
      end
      @(negedge clk_i);
    end
    if (error_count == 0 && assert_failures == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Stop at the first failed controller assertion
  always @(negedge clk_i) begin
    if (assert_failures != 0) begin
      report_failure("a bound controller assertion failed");
    end
  end

  // Halt responder, acknowledges after a random 1 to 8 cycles
  initial begin : halt_responder
    int unsigned cycles;
    int unsigned delay;
    logic [31:0] r;
    for (int n = 0; n < num_recoveries; n++) begin
      cycles = 0;
      while (debug_req_o !== 1'b1) begin
        @(negedge clk_i);
        cycles++;
        if (cycles > idle_timeout) begin
          report_failure("timeout: debug halt request never raised");
        end
      end
      r = next_random();
      delay = 1 + (r % 8);
      repeat (delay) @(posedge clk_i);
      #2;
      debug_halt_i = 1'b1;
      cycles = 0;
      while (debug_resume_o !== 1'b1) begin
        @(negedge clk_i);
        cycles++;
        if (cycles > busy_timeout) begin
          report_failure("timeout: debug resume never raised");
        end
      end
      @(posedge clk_i);
      #2;
      debug_halt_i = 1'b0;
    end
  end

  // Compare process
  initial begin : compare_process
    int unsigned wait_cycles;
    wait_cycles = 0;
    while (rst_ni !== 1'b1) begin
      @(negedge clk_i);
      wait_cycles++;
      if (wait_cycles > 100) begin
        report_failure("timeout: reset was never released");
      end
    end
    for (int unsigned handled = 0; handled < num_recoveries; handled++) begin
      wait_cycles = 0;
      do begin
        @(negedge clk_i);
        check_idle_outputs();
        wait_cycles++;
        if (wait_cycles > idle_timeout) begin
          report_failure("timeout: no start pulse was sent");
        end
      end while (starts_sent == handled);
      check_recovery(handled + 1);
    end
    compare_finished = 1'b1;
  end

endmodule

/* common/recovery_defs.svh */
`ifndef RECOVERY_DEFS_SVH
`define RECOVERY_DEFS_SVH

// Number of architectural registers in the core
`define RR_NUM_REGS 32

// Register address width, log2 of the register count
`define RR_ADDR_W 5

// Register and program counter data width
`define RR_XLEN 32

`endif

/* common/recovery_pkg.sv */
`include "recovery_defs.svh"

package recovery_pkg;

  // Full register file address
  typedef logic [`RR_ADDR_W-1:0] rf_addr_t;

  // Index into one half of the register file, walked by the restore counter
  typedef logic [`RR_ADDR_W-2:0] half_addr_t;

  // Register value
  typedef logic [`RR_XLEN-1:0] rf_data_t;

  // Program counter value
  typedef logic [`RR_XLEN-1:0] pc_t;

  // Two register file write ports
  // Same layout for core writes into the unit and restore writes out of it
  typedef struct packed {
    logic     we_a;
    rf_addr_t waddr_a;
    rf_data_t wdata_a;
    logic     we_b;
    rf_addr_t waddr_b;
    rf_data_t wdata_b;
  } regfile_write_t;

  // Recovery controller states
  typedef enum logic [1:0] {
    IDLE,
    RESET,
    HALT,
    RESTORE
  } recovery_mode_e;

endpackage

/* rapid_recovery.f */
+incdir+common
common/recovery_pkg.sv
recovery_ctrl/recovery_ctrl.sv
rtl/recovery_addr_gen.sv
rtl/backup_regfile.sv
rtl/backup_pc.sv
rtl/rapid_recovery.sv
bench/rapid_recovery_props.sv
bench/rapid_recovery_tb.sv

/* recovery_ctrl/recovery_ctrl.sv */
`timescale 1ns/1ps

module recovery_ctrl (
  input  logic clk_i,
  input  logic rst_ni,

  // Trigger from the fault detection logic
  input  logic start_recovery_i,

  // Core handshake levels
  input  logic debug_halt_i,

  // Last restore step reached, from the address counter
  input  logic restore_done_i,

  // Core control
  output logic setback_o,
  output logic instr_lock_o,
  output logic debug_req_o,
  output logic debug_resume_o,
  output logic recovery_finished_o,

  // Shadow store control
  output logic backup_enable_o,
  output logic restore_enable_o
);

  import recovery_pkg::*;

  recovery_mode_e mode_d, mode_q;

  // Registered control levels
  logic setback_d, setback_q;
  logic instr_lock_d, instr_lock_q;
  logic backup_enable_d, backup_enable_q;

  assign setback_o       = setback_q;
  assign instr_lock_o    = instr_lock_q;
  assign backup_enable_o = backup_enable_q;

  always_comb begin
    // Hold state and levels by default
    mode_d          = mode_q;
    instr_lock_d    = instr_lock_q;
    backup_enable_d = backup_enable_q;
    // Setback is a single cycle pulse
    setback_d       = 1'b0;
    // Strobes decoded from the current state
    debug_req_o         = 1'b0;
    debug_resume_o      = 1'b0;
    recovery_finished_o = 1'b0;
    restore_enable_o    = 1'b0;

    case (mode_q)
      IDLE: begin
        // Start pulse only honoured here
        if (start_recovery_i) begin
          mode_d = RESET;
        end
      end

      RESET: begin
        // Put the core back
        setback_d       = 1'b1;
        // Stop fetching until the restore is over
        instr_lock_d    = 1'b1;
        // Freeze the shadow copy
        backup_enable_d = 1'b0;
        // Single cycle state
        mode_d          = HALT;
      end

      HALT: begin
        // Keep requesting the debug halt
        debug_req_o = 1'b1;
        // Core acknowledged, move on to the replay
        if (debug_halt_i) begin
          mode_d = RESTORE;
        end
      end

      RESTORE: begin
        // Replay one register pair and the PC per cycle
        restore_enable_o = 1'b1;
        // Counter owns the last step decision
        if (restore_done_i) begin
          instr_lock_d        = 1'b0;
          backup_enable_d     = 1'b1;
          debug_resume_o      = 1'b1;
          recovery_finished_o = 1'b1;
          mode_d              = IDLE;
        end
      end

      default: begin
        // Unreachable with a full 2-bit enum, fall back to idle
        mode_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q          <= IDLE;
      setback_q       <= 1'b0;
      instr_lock_q    <= 1'b0;
      // Shadow copy tracks the core from reset onward
      backup_enable_q <= 1'b1;
    end else begin
      mode_q          <= mode_d;
      setback_q       <= setback_d;
      instr_lock_q    <= instr_lock_d;
      backup_enable_q <= backup_enable_d;
    end
  end

endmodule

/* rtl/backup_pc.sv */
`timescale 1ns/1ps

module backup_pc (
  input  logic clk_i,
  input  logic rst_ni,

  // Capture strobed PCs while high
  input  logic backup_enable_i,

  // Present the saved PC while high
  input  logic restore_enable_i,

  // Core program counter and its strobe
  input  recovery_pkg::pc_t core_pc_i,
  input  logic core_pc_valid_i,

  // Saved PC towards the core
  output recovery_pkg::pc_t recovery_pc_o,
  output logic recovery_pc_valid_o
);

  import recovery_pkg::*;

  pc_t pc_q;

  // Strobes during recovery are dropped
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q <= '0;
    end else if (backup_enable_i && core_pc_valid_i) begin
      pc_q <= core_pc_i;
    end
  end

  assign recovery_pc_o = pc_q;

  // Valid for every restore cycle
  assign recovery_pc_valid_o = restore_enable_i;

endmodule

/* rtl/backup_regfile.sv */
`timescale 1ns/1ps

`include "recovery_defs.svh"

module backup_regfile (
  input  logic clk_i,
  input  logic rst_ni,

  // Mirror core writes while high
  input  logic backup_enable_i,

  // Drive the paired restore write while high
  input  logic restore_enable_i,

  // Core register file write ports being watched
  input  recovery_pkg::regfile_write_t core_write_i,

  // Restore index into the lower half
  input  recovery_pkg::half_addr_t restore_idx_i,

  // Paired write back into the core
  output recovery_pkg::regfile_write_t restore_write_o
);

  import recovery_pkg::*;

  // Shadow storage
  rf_data_t mem_q [`RR_NUM_REGS];

  // Restore addresses, lower half and the matching upper half entry
  rf_addr_t lo_addr;
  rf_addr_t hi_addr;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `RR_NUM_REGS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (backup_enable_i) begin
      if (core_write_i.we_a) begin
        mem_q[core_write_i.waddr_a] <= core_write_i.wdata_a;
      end
      // Later assignment, so port b wins on an address clash
      if (core_write_i.we_b) begin
        mem_q[core_write_i.waddr_b] <= core_write_i.wdata_b;
      end
    end
  end

  // Top address bit selects the half, same as adding half the file size
  assign lo_addr = {1'b0, restore_idx_i};
  assign hi_addr = {1'b1, restore_idx_i};

  // Port a restores the lower half
  assign restore_write_o.we_a    = restore_enable_i;
  assign restore_write_o.waddr_a = lo_addr;
  assign restore_write_o.wdata_a = mem_q[lo_addr];

  // Port b restores the upper half
  assign restore_write_o.we_b    = restore_enable_i;
  assign restore_write_o.waddr_b = hi_addr;
  assign restore_write_o.wdata_b = mem_q[hi_addr];

endmodule

/* rtl/rapid_recovery.sv */
`timescale 1ns/1ps

`include "recovery_defs.svh"

module rapid_recovery (
  input  logic clk_i,
  input  logic rst_ni,

  // Fault detection trigger
  input  logic start_recovery_i,

  // Core state being shadowed
  input  recovery_pkg::regfile_write_t core_rf_write_i,
  input  recovery_pkg::pc_t core_pc_i,
  input  logic core_pc_valid_i,

  // Core halt acknowledge level
  input  logic debug_halt_i,

  // Restore path into the core
  output recovery_pkg::regfile_write_t recovery_rf_write_o,
  output recovery_pkg::pc_t recovery_pc_o,
  output logic recovery_pc_valid_o,

  // Core control
  output logic setback_o,
  output logic instr_lock_o,
  output logic debug_req_o,
  output logic debug_resume_o,

  // Status
  output logic recovery_finished_o
);

  import recovery_pkg::*;

  logic       backup_enable;
  logic       restore_enable;
  half_addr_t restore_idx;
  logic       restore_done;

  // Sequencer for setback, halt, restore and resume
  recovery_ctrl recovery_ctrl_inst (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .start_recovery_i    (start_recovery_i),
    .debug_halt_i        (debug_halt_i),
    .restore_done_i      (restore_done),
    .setback_o           (setback_o),
    .instr_lock_o        (instr_lock_o),
    .debug_req_o         (debug_req_o),
    .debug_resume_o      (debug_resume_o),
    .recovery_finished_o (recovery_finished_o),
    .backup_enable_o     (backup_enable),
    .restore_enable_o    (restore_enable)
  );

  // Walks half the register file, one pair per cycle
  recovery_addr_gen #(
    .AddrWidth (`RR_ADDR_W - 1)
  ) recovery_addr_gen_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .enable_i  (restore_enable),
    .address_o (restore_idx),
    .done_o    (restore_done)
  );

  // Shadow register file
  backup_regfile backup_regfile_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .backup_enable_i  (backup_enable),
    .restore_enable_i (restore_enable),
    .core_write_i     (core_rf_write_i),
    .restore_idx_i    (restore_idx),
    .restore_write_o  (recovery_rf_write_o)
  );

  // Shadow program counter
  backup_pc backup_pc_inst (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .backup_enable_i     (backup_enable),
    .restore_enable_i    (restore_enable),
    .core_pc_i           (core_pc_i),
    .core_pc_valid_i     (core_pc_valid_i),
    .recovery_pc_o       (recovery_pc_o),
    .recovery_pc_valid_o (recovery_pc_valid_o)
  );

endmodule

/* rtl/recovery_addr_gen.sv */
`timescale 1ns/1ps

module recovery_addr_gen #(
  parameter int unsigned AddrWidth = 4
) (
  input  logic clk_i,
  input  logic rst_ni,

  // Step the address, high during every restore cycle
  input  logic enable_i,

  // Current half file index
  output recovery_pkg::half_addr_t address_o,

  // Current index is the last one
  output logic done_o
);

  import recovery_pkg::*;

  logic [AddrWidth-1:0] count_d, count_q;

  // Natural overflow wraps the maximum back to zero
  always_comb begin
    count_d = count_q;
    if (enable_i) begin
      count_d = count_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else begin
      count_q <= count_d;
    end
  end

  // Resized onto the shared index type
  assign address_o = half_addr_t'(count_q);

  // All-ones decode marks the final step
  assign done_o = &count_q;

endmodule
